// File: rtl/rv_isa_pkg.sv
// RISC-V RV64I instruction encodings, instruction-word views and decode kinds; import where needed
package rv_isa_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int NR_REGS    = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  // same 32 bits seen as register or immediate layout
  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
  } rv_inst_u;

  typedef enum logic [2:0] {
    FMT_I    = 3'd0,
    FMT_U    = 3'd1,
    FMT_S    = 3'd2,
    FMT_B    = 3'd3,
    FMT_J    = 3'd4,
    FMT_NONE = 3'd7
  } imm_fmt_e;

  typedef enum logic [5:0] {
    KIND_NONE,                                          // all-zero word
    KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR,
    KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
    KIND_LB, KIND_LH, KIND_LW, KIND_LD, KIND_LBU, KIND_LHU, KIND_LWU,
    KIND_SB, KIND_SH, KIND_SW, KIND_SD,
    KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI, KIND_ANDI,
    KIND_SLLI, KIND_SRLI, KIND_SRAI,
    KIND_ADD, KIND_SUB, KIND_SLL, KIND_SLT, KIND_SLTU,
    KIND_XOR, KIND_SRL, KIND_SRA, KIND_OR, KIND_AND,
    KIND_ADDIW, KIND_SLLIW, KIND_SRLIW, KIND_SRAIW,
    KIND_ADDW, KIND_SUBW, KIND_SLLW, KIND_SRLW, KIND_SRAW,
    KIND_INVALID
  } inst_kind_e;

endpackage

// File: rtl/idu_ctrl_pkg.sv
// datapath control encodings produced by the decode stage for ALU, memory and branch units
package idu_ctrl_pkg;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_COPY_IMM = 5'd15,  // passes operand b through
    ALU_INVALID  = 5'd31
  } alu_op_e;

  // stores reuse the signed code of their size
  typedef enum logic [2:0] {
    MEM_LB   = 3'd0,
    MEM_LBU  = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LHU  = 3'd3,
    MEM_LW   = 3'd4,
    MEM_LWU  = 3'd5,
    MEM_LD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_JAL  = 3'd0,
    BR_JALR = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BNE  = 3'd3,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } br_func_e;

  typedef enum logic {
    A_SRC_RS1 = 1'b0,
    A_SRC_PC  = 1'b1
  } alu_a_src_e;

  typedef enum logic [1:0] {
    B_SRC_RS2  = 2'd0,
    B_SRC_IMM  = 2'd1,
    B_SRC_FOUR = 2'd2   // return address pc + 4
  } alu_b_src_e;

endpackage

// File: rtl/idu_decoder.sv
// instruction latch and RV64I matcher; gives the instruction kind and immediate format
`timescale 1ns/1ns

module idu_decoder (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_inst_valid,
  input  rv_isa_pkg::rv_inst_u   i_inst,
  output rv_isa_pkg::rv_inst_u   o_inst,
  output rv_isa_pkg::inst_kind_e o_kind,
  output rv_isa_pkg::imm_fmt_e   o_fmt
);
  import rv_isa_pkg::*;

  rv_inst_u   inst_q;
  inst_kind_e kind;
  imm_fmt_e   fmt;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      inst_q <= '0;
    end else if (i_inst_valid) begin
      inst_q <= i_inst;
    end
  end

  assign opcode = inst_q.r.opcode;
  assign funct3 = inst_q.r.funct3;
  assign funct7 = inst_q.r.funct7;

  always_comb begin
    kind = KIND_INVALID;
    case (opcode)
      OPC_LUI:   kind = KIND_LUI;
      OPC_AUIPC: kind = KIND_AUIPC;
      OPC_JAL:   kind = KIND_JAL;
      OPC_JALR:  if (funct3 == 3'b000) kind = KIND_JALR;
      OPC_BRANCH:
        case (funct3)
          3'b000:  kind = KIND_BEQ;
          3'b001:  kind = KIND_BNE;
          3'b100:  kind = KIND_BLT;
          3'b101:  kind = KIND_BGE;
          3'b110:  kind = KIND_BLTU;
          3'b111:  kind = KIND_BGEU;
          default: kind = KIND_INVALID;
        endcase
      OPC_LOAD:
        case (funct3)
          3'b000:  kind = KIND_LB;
          3'b001:  kind = KIND_LH;
          3'b010:  kind = KIND_LW;
          3'b011:  kind = KIND_LD;
          3'b100:  kind = KIND_LBU;
          3'b101:  kind = KIND_LHU;
          3'b110:  kind = KIND_LWU;
          default: kind = KIND_INVALID;
        endcase
      OPC_STORE:
        case (funct3)
          3'b000:  kind = KIND_SB;
          3'b001:  kind = KIND_SH;
          3'b010:  kind = KIND_SW;
          3'b011:  kind = KIND_SD;
          default: kind = KIND_INVALID;
        endcase
      OPC_OP_IMM:
        case (funct3)
          3'b000: kind = KIND_ADDI;
          3'b010: kind = KIND_SLTI;
          3'b011: kind = KIND_SLTIU;
          3'b100: kind = KIND_XORI;
          3'b110: kind = KIND_ORI;
          3'b111: kind = KIND_ANDI;
          3'b001: if (funct7[6:1] == 6'b000000) kind = KIND_SLLI;  // shamt[5] in bit 25
          default: begin
            if (funct7[6:1] == 6'b000000) kind = KIND_SRLI;
            else if (funct7[6:1] == 6'b010000) kind = KIND_SRAI;
          end
        endcase
      OPC_OP_IMM_32:
        case ({funct7, funct3})
          10'b0000000_001: kind = KIND_SLLIW;
          10'b0000000_101: kind = KIND_SRLIW;
          10'b0100000_101: kind = KIND_SRAIW;
          default: if (funct3 == 3'b000) kind = KIND_ADDIW;
        endcase
      OPC_OP:
        case ({funct7, funct3})
          10'b0000000_000: kind = KIND_ADD;
          10'b0100000_000: kind = KIND_SUB;
          10'b0000000_001: kind = KIND_SLL;
          10'b0000000_010: kind = KIND_SLT;
          10'b0000000_011: kind = KIND_SLTU;
          10'b0000000_100: kind = KIND_XOR;
          10'b0000000_101: kind = KIND_SRL;
          10'b0100000_101: kind = KIND_SRA;
          10'b0000000_110: kind = KIND_OR;
          10'b0000000_111: kind = KIND_AND;
          default:         kind = KIND_INVALID;  // M extension lands here
        endcase
      OPC_OP_32:
        case ({funct7, funct3})
          10'b0000000_000: kind = KIND_ADDW;
          10'b0100000_000: kind = KIND_SUBW;
          10'b0000000_001: kind = KIND_SLLW;
          10'b0000000_101: kind = KIND_SRLW;
          10'b0100000_101: kind = KIND_SRAW;
          default:         kind = KIND_INVALID;
        endcase
      default: kind = KIND_INVALID;  // system and unused opcodes
    endcase
    if (inst_q == '0) kind = KIND_NONE;
  end

  always_comb begin
    fmt = FMT_NONE;
    if (kind != KIND_INVALID) begin
      case (opcode)
        OPC_LOAD, OPC_JALR, OPC_OP_IMM, OPC_OP_IMM_32: fmt = FMT_I;
        OPC_STORE:             fmt = FMT_S;
        OPC_BRANCH:            fmt = FMT_B;
        OPC_LUI, OPC_AUIPC:    fmt = FMT_U;
        OPC_JAL:               fmt = FMT_J;
        default:               fmt = FMT_NONE;  // R type
      endcase
    end
  end

  assign o_inst = inst_q;
  assign o_kind = kind;
  assign o_fmt  = fmt;

  a_none_fmt: assert property (@(posedge i_clk) disable iff (i_reset)
    (kind == KIND_NONE) |-> (fmt == FMT_NONE))
    else $error("zero word decoded with immediate format %0d", fmt);

endmodule

// File: rtl/idu_imm_gen.sv
// immediate generator; sign-extends the I, U, S, B or J field of the latched word to XLEN
`timescale 1ns/1ns

module idu_imm_gen (
  input  rv_isa_pkg::rv_inst_u         i_inst,
  input  rv_isa_pkg::imm_fmt_e         i_fmt,
  output logic [rv_isa_pkg::XLEN-1:0] o_imm
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            sign;

  assign sign  = i_inst[31];
  assign imm_i = {{(XLEN-12){sign}}, i_inst.i.imm12};
  assign imm_u = {{(XLEN-32){sign}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){sign}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{(XLEN-20){sign}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      FMT_I:   o_imm = imm_i;
      FMT_U:   o_imm = imm_u;
      FMT_S:   o_imm = imm_s;
      FMT_B:   o_imm = imm_b;
      FMT_J:   o_imm = imm_j;
      default: o_imm = '0;  // R type, none, invalid
    endcase
  end

endmodule

// File: rtl/idu_ctrl_gen.sv
// control encoder; turns the decoded instruction kind into ALU, memory and branch controls
`timescale 1ns/1ns

module idu_ctrl_gen (
  input  rv_isa_pkg::inst_kind_e   i_kind,
  output idu_ctrl_pkg::alu_op_e    o_alu_op,
  output idu_ctrl_pkg::alu_a_src_e o_alu_a_src,
  output idu_ctrl_pkg::alu_b_src_e o_alu_b_src,
  output logic                     o_reg_wr,
  output logic                     o_mem_re,
  output logic                     o_mem_wr,
  output idu_ctrl_pkg::mem_op_e    o_mem_op,
  output logic                     o_br_en,
  output idu_ctrl_pkg::br_func_e   o_br_func,
  output logic                     o_word_cut,
  output logic                     o_invalid
);
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;

  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_jump;
  logic is_op_imm;
  logic is_upper;

  assign is_load   = i_kind inside {KIND_LB, KIND_LH, KIND_LW, KIND_LD,
                                    KIND_LBU, KIND_LHU, KIND_LWU};
  assign is_store  = i_kind inside {KIND_SB, KIND_SH, KIND_SW, KIND_SD};
  assign is_branch = i_kind inside {KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE,
                                    KIND_BLTU, KIND_BGEU};
  assign is_jump   = i_kind inside {KIND_JAL, KIND_JALR};
  assign is_op_imm = i_kind inside {KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI,
                                    KIND_ANDI, KIND_SLLI, KIND_SRLI, KIND_SRAI,
                                    KIND_ADDIW, KIND_SLLIW, KIND_SRLIW, KIND_SRAIW};
  assign is_upper  = i_kind inside {KIND_LUI, KIND_AUIPC};

  always_comb begin
    case (i_kind)
      KIND_LUI: o_alu_op = ALU_COPY_IMM;
      KIND_AUIPC, KIND_JAL, KIND_JALR, KIND_ADDI, KIND_ADD, KIND_ADDIW, KIND_ADDW,
      KIND_LB, KIND_LH, KIND_LW, KIND_LD, KIND_LBU, KIND_LHU, KIND_LWU,
      KIND_SB, KIND_SH, KIND_SW, KIND_SD: o_alu_op = ALU_ADD;
      KIND_SUB, KIND_SUBW, KIND_BEQ, KIND_BNE: o_alu_op = ALU_SUB;  // equality via difference
      KIND_SLT, KIND_SLTI, KIND_BLT, KIND_BGE: o_alu_op = ALU_SLT;
      KIND_SLTU, KIND_SLTIU, KIND_BLTU, KIND_BGEU: o_alu_op = ALU_SLTU;
      KIND_XOR, KIND_XORI: o_alu_op = ALU_XOR;
      KIND_AND, KIND_ANDI: o_alu_op = ALU_AND;
      KIND_OR, KIND_ORI: o_alu_op = ALU_OR;
      KIND_SLL, KIND_SLLI, KIND_SLLIW, KIND_SLLW: o_alu_op = ALU_SLL;
      KIND_SRL, KIND_SRLI, KIND_SRLIW, KIND_SRLW: o_alu_op = ALU_SRL;
      KIND_SRA, KIND_SRAI, KIND_SRAIW, KIND_SRAW: o_alu_op = ALU_SRA;
      default: o_alu_op = ALU_INVALID;
    endcase
  end

  always_comb begin
    case (i_kind)
      KIND_LB, KIND_SB: o_mem_op = MEM_LB;
      KIND_LBU:         o_mem_op = MEM_LBU;
      KIND_LH, KIND_SH: o_mem_op = MEM_LH;
      KIND_LHU:         o_mem_op = MEM_LHU;
      KIND_LW, KIND_SW: o_mem_op = MEM_LW;
      KIND_LWU:         o_mem_op = MEM_LWU;
      KIND_LD, KIND_SD: o_mem_op = MEM_LD;
      default:          o_mem_op = MEM_NONE;
    endcase
  end

  always_comb begin
    case (i_kind)
      KIND_JALR: o_br_func = BR_JALR;
      KIND_BEQ:  o_br_func = BR_BEQ;
      KIND_BNE:  o_br_func = BR_BNE;
      KIND_BLT:  o_br_func = BR_BLT;
      KIND_BGE:  o_br_func = BR_BGE;
      KIND_BLTU: o_br_func = BR_BLTU;
      KIND_BGEU: o_br_func = BR_BGEU;
      default:   o_br_func = BR_JAL;  // ignored while o_br_en is low
    endcase
  end

  always_comb begin
    if (is_jump) begin
      o_alu_b_src = B_SRC_FOUR;
    end else if (is_load || is_store || is_op_imm || is_upper) begin
      o_alu_b_src = B_SRC_IMM;
    end else begin
      o_alu_b_src = B_SRC_RS2;
    end
  end

  assign o_alu_a_src = (is_jump || i_kind == KIND_AUIPC) ? A_SRC_PC : A_SRC_RS1;
  assign o_reg_wr    = !(is_store || is_branch || i_kind == KIND_NONE ||
                         i_kind == KIND_INVALID);
  assign o_mem_re    = is_load;
  assign o_mem_wr    = is_store;
  assign o_br_en     = is_branch || is_jump;
  assign o_word_cut  = i_kind inside {KIND_ADDIW, KIND_SLLIW, KIND_SRLIW, KIND_SRAIW,
                                      KIND_ADDW, KIND_SUBW, KIND_SLLW, KIND_SRLW, KIND_SRAW};
  assign o_invalid   = (i_kind == KIND_INVALID);

  // access size table must agree with the load and store sets
  a_mem_excl: assert final (!(o_mem_re && o_mem_wr) &&
                            ((o_mem_re || o_mem_wr) == (o_mem_op != MEM_NONE)))
    else $error("memory controls disagree for kind %0d", i_kind);

endmodule

// File: rtl/idu_gpr.sv
// general register file, two async reads and one clocked write, x0 hardwired to zero
`timescale 1ns/1ns

module idu_gpr #(
  parameter int DATA_W = 64
) (
  input  logic                              i_clk,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_raddr1,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_raddr2,
  input  logic                              i_wen,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_waddr,
  input  logic [DATA_W-1:0]                 i_wdata,
  output logic [DATA_W-1:0]                 o_rdata1,
  output logic [DATA_W-1:0]                 o_rdata2
);
  import rv_isa_pkg::*;

  logic [DATA_W-1:0] regs [NR_REGS];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, same-cycle write shows up next cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  a_waddr_known: assert property (@(posedge i_clk)
    i_wen |-> !$isunknown(i_waddr))
    else $error("write-back enabled with unknown address");

endmodule

// File: rtl/idu_top.sv
// decode stage top level; connects latch/matcher, immediate and control encoders and the GPRs
`timescale 1ns/1ns

module idu_top (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_inst_valid,
  input  logic [rv_isa_pkg::INST_W-1:0]     i_inst,
  input  logic                              i_wb_wen,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_wb_waddr,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_wb_wdata,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rd,
  output logic [rv_isa_pkg::XLEN-1:0]       o_rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_rs2_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_imm,
  output idu_ctrl_pkg::alu_op_e             o_alu_op,
  output idu_ctrl_pkg::alu_a_src_e          o_alu_a_src,
  output idu_ctrl_pkg::alu_b_src_e          o_alu_b_src,
  output logic                              o_reg_wr,
  output logic                              o_mem_re,
  output logic                              o_mem_wr,
  output idu_ctrl_pkg::mem_op_e             o_mem_op,
  output logic                              o_br_en,
  output idu_ctrl_pkg::br_func_e            o_br_func,
  output logic                              o_word_cut,
  output logic                              o_invalid
);
  import rv_isa_pkg::*;

  rv_inst_u   inst;  // latched word
  inst_kind_e kind;
  imm_fmt_e   fmt;

  idu_decoder u_decoder (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst       (inst),
    .o_kind       (kind),
    .o_fmt        (fmt)
  );

  idu_imm_gen u_imm_gen (
    .i_inst (inst),
    .i_fmt  (fmt),
    .o_imm  (o_imm)
  );

  idu_ctrl_gen u_ctrl_gen (
    .i_kind      (kind),
    .o_alu_op    (o_alu_op),
    .o_alu_a_src (o_alu_a_src),
    .o_alu_b_src (o_alu_b_src),
    .o_reg_wr    (o_reg_wr),
    .o_mem_re    (o_mem_re),
    .o_mem_wr    (o_mem_wr),
    .o_mem_op    (o_mem_op),
    .o_br_en     (o_br_en),
    .o_br_func   (o_br_func),
    .o_word_cut  (o_word_cut),
    .o_invalid   (o_invalid)
  );

  idu_gpr #(
    .DATA_W (XLEN)
  ) u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (inst.r.rs1),
    .i_raddr2 (inst.r.rs2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  assign o_rd = inst.r.rd;

endmodule

// File: tb/tb_idu_vectors.svh
// decode vector table for tb_idu; included in the testbench module body and built once at start
  // columns: word, immediate, ALU op, operand a, operand b, mem op, branch function, flags
  // flags are {reg_wr, mem_re, mem_wr, br_en, word_cut, invalid}
  task automatic build_table;
    logic [XLEN-1:0] bits;
    logic [31:0]     odd_word;
    draw_bits(25, bits);
    odd_word = {bits[24:0], 7'b0001011};  // custom-0 opcode, not RV64I
    add_vec(32'hfff10093, -1, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h00512093, 5, ALU_SLT, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h00513093, 5, ALU_SLTU, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h7ff14093, 2047, ALU_XOR, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h80016093, -2048, ALU_OR, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h00f17093, 15, ALU_AND, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h03f11093, 63, ALU_SLL, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h02115093, 33, ALU_SRL, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h42815093, 1064, ALU_SRA, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003100b3, 0, ALU_ADD, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h403100b3, 0, ALU_SUB, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003110b3, 0, ALU_SLL, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003120b3, 0, ALU_SLT, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003130b3, 0, ALU_SLTU, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003140b3, 0, ALU_XOR, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003150b3, 0, ALU_SRL, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h403150b3, 0, ALU_SRA, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003160b3, 0, ALU_OR, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'h003170b3, 0, ALU_AND, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100000);
    add_vec(32'hffb1009b, -5, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h01f1109b, 31, ALU_SLL, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h0031509b, 3, ALU_SRL, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h4071509b, 1031, ALU_SRA, A_SRC_RS1, B_SRC_IMM, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h003100bb, 0, ALU_ADD, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h403100bb, 0, ALU_SUB, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h403150bb, 0, ALU_SRA, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b100010);
    add_vec(32'h800000b7, -64'sd2147483648, ALU_COPY_IMM, A_SRC_RS1, B_SRC_IMM, MEM_NONE,
            BR_JAL, 6'b100000);  // U value with bit 31 set
    add_vec(32'h12345097, 305418240, ALU_ADD, A_SRC_PC, B_SRC_IMM, MEM_NONE, BR_JAL,
            6'b100000);
    add_vec(32'hff9ff0ef, -8, ALU_ADD, A_SRC_PC, B_SRC_FOUR, MEM_NONE, BR_JAL, 6'b100100);
    add_vec(32'h010100e7, 16, ALU_ADD, A_SRC_PC, B_SRC_FOUR, MEM_NONE, BR_JALR, 6'b100100);
    add_vec(32'h00110083, 1, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LB, BR_JAL, 6'b110000);
    add_vec(32'h00211083, 2, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LH, BR_JAL, 6'b110000);
    add_vec(32'hff412083, -12, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LW, BR_JAL, 6'b110000);
    add_vec(32'h00813083, 8, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LD, BR_JAL, 6'b110000);
    add_vec(32'h00014083, 0, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LBU, BR_JAL, 6'b110000);
    add_vec(32'h7fe15083, 2046, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LHU, BR_JAL, 6'b110000);
    add_vec(32'h00416083, 4, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LWU, BR_JAL, 6'b110000);
    add_vec(32'h003102a3, 5, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LB, BR_JAL, 6'b001000);
    add_vec(32'h00311323, 6, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LH, BR_JAL, 6'b001000);
    add_vec(32'h02312423, 40, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LW, BR_JAL, 6'b001000);
    add_vec(32'hfe313823, -16, ALU_ADD, A_SRC_RS1, B_SRC_IMM, MEM_LD, BR_JAL, 6'b001000);
    add_vec(32'hfe310ee3, -4, ALU_SUB, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_BEQ, 6'b000100);
    add_vec(32'h00311463, 8, ALU_SUB, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_BNE, 6'b000100);
    add_vec(32'h00314863, 16, ALU_SLT, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_BLT, 6'b000100);
    add_vec(32'h003150e3, 2048, ALU_SLT, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_BGE, 6'b000100);
    add_vec(32'h02316063, 32, ALU_SLTU, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_BLTU, 6'b000100);
    add_vec(32'h80317063, -4096, ALU_SLTU, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_BGEU,
            6'b000100);
    add_vec(32'h023100b3, 0, ALU_INVALID, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b000001);
    add_vec(32'h00000073, 0, ALU_INVALID, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b000001);
    add_vec(32'h00000000, 0, ALU_INVALID, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b000000);
    add_vec(odd_word, 0, ALU_INVALID, A_SRC_RS1, B_SRC_RS2, MEM_NONE, BR_JAL, 6'b000001);
  endtask

// File: tb/tb_idu.sv
// testbench for idu_top; runs the decode vector table, the register file test and a watchdog
`timescale 1ns/1ns

module tb_idu;
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 5;
  localparam int REG_CYCLES   = 56;  // 32 writes, 16 reads, hold test, margin

  typedef struct packed {
    logic [31:0]     word;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    alu_a_src_e      a_src;
    alu_b_src_e      b_src;
    mem_op_e         mem_op;
    br_func_e        br_func;
    logic [5:0]      flags;
  } vec_t;

  logic                  clk;
  logic                  reset;
  logic                  inst_valid;
  logic [INST_W-1:0]     inst;
  logic                  wb_wen;
  logic [REG_ADDR_W-1:0] wb_waddr;
  logic [XLEN-1:0]       wb_wdata;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       imm;
  alu_op_e               alu_op;
  alu_a_src_e            a_src;
  alu_b_src_e            b_src;
  logic                  reg_wr;
  logic                  mem_re;
  logic                  mem_wr;
  mem_op_e               mem_op;
  logic                  br_en;
  br_func_e              br_func;
  logic                  word_cut;
  logic                  invalid;

  vec_t            vecs[$];
  logic [31:0]     lfsr;
  logic [XLEN-1:0] model [NR_REGS];  // expected register contents
  bit              table_ready = 1'b0;

  idu_top dut0 (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .i_wb_wen     (wb_wen),
    .i_wb_waddr   (wb_waddr),
    .i_wb_wdata   (wb_wdata),
    .o_rd         (rd),
    .o_rs1_data   (rs1_data),
    .o_rs2_data   (rs2_data),
    .o_imm        (imm),
    .o_alu_op     (alu_op),
    .o_alu_a_src  (a_src),
    .o_alu_b_src  (b_src),
    .o_reg_wr     (reg_wr),
    .o_mem_re     (mem_re),
    .o_mem_wr     (mem_wr),
    .o_mem_op     (mem_op),
    .o_br_en      (br_en),
    .o_br_func    (br_func),
    .o_word_cut   (word_cut),
    .o_invalid    (invalid)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [XLEN-1:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[XLEN-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic add_vec(input logic [31:0] word, input longint e_imm, input alu_op_e e_alu,
                         input alu_a_src_e e_a, input alu_b_src_e e_b, input mem_op_e e_mem,
                         input br_func_e e_br, input logic [5:0] e_flags);
    vec_t v;
    v.word    = word;
    v.imm     = e_imm;
    v.alu_op  = e_alu;
    v.a_src   = e_a;
    v.b_src   = e_b;
    v.mem_op  = e_mem;
    v.br_func = e_br;
    v.flags   = e_flags;
    vecs.push_back(v);
  endtask

  `include "tb_idu_vectors.svh"

  task automatic check_failed(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "decode stage check failed");
  endtask

  task automatic check_outputs(input vec_t v);
    logic [5:0] flags;
    flags = {reg_wr, mem_re, mem_wr, br_en, word_cut, invalid};
    assert (imm === v.imm)
      else check_failed($sformatf("word %h: imm %h, expected %h", v.word, imm, v.imm));
    assert (alu_op === v.alu_op)
      else check_failed($sformatf("word %h: alu op %0d, expected %0d", v.word, alu_op,
                                  v.alu_op));
    assert ({a_src, b_src} === {v.a_src, v.b_src})
      else check_failed($sformatf("word %h: operand sources %0d/%0d, expected %0d/%0d",
                                  v.word, a_src, b_src, v.a_src, v.b_src));
    assert (mem_op === v.mem_op)
      else check_failed($sformatf("word %h: mem op %0d, expected %0d", v.word, mem_op,
                                  v.mem_op));
    assert (flags === v.flags)
      else check_failed($sformatf("word %h: flags %b, expected %b", v.word, flags, v.flags));
    if (v.flags[2]) begin  // branch function only means something with br_en
      assert (br_func === v.br_func)
        else check_failed($sformatf("word %h: branch func %0d, expected %0d", v.word,
                                    br_func, v.br_func));
    end
  endtask

  initial begin
    logic [XLEN-1:0]       data;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rd_exp;
    int                    r;
    lfsr       = 32'hb0554f91;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    wb_wen     = 1'b0;
    wb_waddr   = '0;
    wb_wdata   = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert ({reg_wr, mem_wr, mem_re, br_en, word_cut, invalid} === 6'b0)
      else check_failed("control outputs active after reset");
    assert (mem_op === MEM_NONE)
      else check_failed($sformatf("mem op %0d after reset, expected none", mem_op));

    foreach (vecs[i]) begin
      inst       = vecs[i].word;
      inst_valid = 1'b1;
      @(negedge clk);
      check_outputs(vecs[i]);
    end

    // new word without valid must not disturb the decode
    inst       = 32'hfe313823;
    inst_valid = 1'b0;
    repeat (2) @(negedge clk);
    check_outputs(vecs[vecs.size() - 1]);

    model[0] = '0;
    wb_wen   = 1'b1;
    for (r = 1; r < NR_REGS; r++) begin
      draw_bits(XLEN, data);
      wb_waddr = r[REG_ADDR_W-1:0];
      wb_wdata = data;
      model[r] = data;
      @(negedge clk);
    end
    draw_bits(XLEN, data);
    wb_waddr = '0;  // x0 keeps reading zero
    wb_wdata = data;
    @(negedge clk);
    wb_wen = 1'b0;

    for (r = 0; r < NR_REGS; r += 2) begin
      ra         = r[REG_ADDR_W-1:0];
      rd_exp     = REG_ADDR_W'(NR_REGS - 1 - r);
      inst       = {7'b0, ra + 5'd1, ra, 3'b000, ~ra, OPC_OP};  // add x(31-ra), ra, ra+1
      inst_valid = 1'b1;
      @(negedge clk);
      assert (rd === rd_exp)
        else check_failed($sformatf("rd %0d, expected %0d", rd, rd_exp));
      assert (rs1_data === model[r])
        else check_failed($sformatf("x%0d read %h, expected %h", r, rs1_data, model[r]));
      assert (rs2_data === model[r + 1])
        else check_failed($sformatf("x%0d read %h, expected %h", r + 1, rs2_data,
                                    model[r + 1]));
    end
    inst_valid = 1'b0;

    $display("** PASS **");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((vecs.size() + REG_CYCLES + RESET_CYCLES) * 2 * PERIOD);
    $display("timeout: the decode stage test did not finish in its cycle budget");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: filelist.f
+incdir+tb
rtl/rv_isa_pkg.sv
rtl/idu_ctrl_pkg.sv
rtl/idu_decoder.sv
rtl/idu_imm_gen.sv
rtl/idu_ctrl_gen.sv
rtl/idu_gpr.sv
rtl/idu_top.sv
tb/tb_idu.sv
